/* hdl/soc_bus_pkg.sv */
package soc_bus_pkg;

    // bus byte address and data word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    typedef logic [3:0] strb_t;   // one strobe per byte lane, all clear is a read

    // UART and LED data
    typedef logic [7:0] byte_t;

    // region selector taken from the top address nibble
    typedef logic [3:0] region_t;

    localparam int REGION_MSB = 31;   // top bit of the selector field

    localparam region_t REGION_ROM = 4'd1;
    localparam region_t REGION_RAM = 4'd2;
    localparam region_t REGION_PORT = 4'd3;
    localparam region_t REGION_UART_DATA = 4'd4;
    localparam region_t REGION_UART_STATUS = 4'd5;

    // every other code is unmapped and reads as zero

endpackage

/* hdl/byte_fifo.sv */
`timescale 1ns/100ps

module byte_fifo #(
    parameter int FIFO_BITS = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  soc_bus_pkg::byte_t  din,
    input  logic                pop,
    output soc_bus_pkg::byte_t  dout,
    output logic                full,
    output logic                empty
);
    localparam int DEPTH = 1 << FIFO_BITS;

    soc_bus_pkg::byte_t fifo_mem [0:DEPTH-1];
    logic [FIFO_BITS:0] wr_ptr;   // extra top bit tells full from empty
    logic [FIFO_BITS:0] rd_ptr;
    logic               do_push;
    logic               do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[FIFO_BITS] != rd_ptr[FIFO_BITS]) &&
                  (wr_ptr[FIFO_BITS-1:0] == rd_ptr[FIFO_BITS-1:0]);
    assign do_push = push && !full;
    assign do_pop = pop && !empty;
    assign dout = fifo_mem[rd_ptr[FIFO_BITS-1:0]];   // head is visible before the pop

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            fifo_mem[wr_ptr[FIFO_BITS-1:0]] <= din;
        end
    end

endmodule

/* hdl/uart_fifo.sv */
`timescale 1ns/100ps

module uart_fifo #(
    parameter int FIFO_BITS = 2,
    parameter int CLK_DIV = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                uart_req,
    input  logic                uart_wr,
    input  soc_bus_pkg::byte_t  wdata,
    input  logic                status_rd,
    input  logic                rx,
    output logic                uart_ack,
    output soc_bus_pkg::byte_t  rdata,
    output logic                tx_full,
    output logic                rx_empty,
    output logic                overrun,
    output logic                tx
);
    localparam int CNT_W = $clog2(CLK_DIV);
    localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLK_DIV - 1);
    localparam logic [CNT_W-1:0] BIT_MID = CNT_W'(CLK_DIV / 2 - 1);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    tx_state_t          tx_state;
    rx_state_t          rx_state;
    logic [CNT_W-1:0]   tx_cnt;
    logic [CNT_W-1:0]   rx_cnt;
    logic [2:0]         tx_bit;
    logic [2:0]         rx_bit;
    soc_bus_pkg::byte_t tx_shift;
    soc_bus_pkg::byte_t rx_shift;
    soc_bus_pkg::byte_t tx_dout;
    soc_bus_pkg::byte_t rx_dout;
    logic               tx_push, tx_pop, tx_empty, tx_bit_end;
    logic               rx_push, rx_pop, rx_full, rx_mid, rx_end;
    logic               rx_meta, rx_sync;

    // bus side, the ack pulse also keeps a held request from being served twice
    assign tx_push = uart_req && uart_wr && !tx_full && !uart_ack;
    assign rx_pop = uart_req && !uart_wr && !rx_empty && !uart_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) uart_ack <= 1'b0;
        else uart_ack <= tx_push || rx_pop;
    end

    always_ff @(posedge clk) begin
        if (rx_pop) rdata <= rx_dout;
    end

    byte_fifo #(.FIFO_BITS(FIFO_BITS)) u_tx_fifo (
        .clk(clk), .rst_n(rst_n), .push(tx_push), .din(wdata), .pop(tx_pop),
        .dout(tx_dout), .full(tx_full), .empty(tx_empty)
    );

    byte_fifo #(.FIFO_BITS(FIFO_BITS)) u_rx_fifo (
        .clk(clk), .rst_n(rst_n), .push(rx_push), .din(rx_shift), .pop(rx_pop),
        .dout(rx_dout), .full(rx_full), .empty(rx_empty)
    );

    assign tx_pop = (tx_state == TX_IDLE) && !tx_empty;
    assign tx_bit_end = (tx_cnt == BIT_END);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_state <= TX_IDLE;
            tx_cnt <= '0;
            tx_bit <= '0;
        end else begin
            if (tx_state == TX_IDLE || tx_bit_end) tx_cnt <= '0;
            else tx_cnt <= tx_cnt + 1'b1;
            case (tx_state)
                TX_IDLE: if (!tx_empty) tx_state <= TX_START;
                TX_START: begin
                    tx_bit <= '0;
                    if (tx_bit_end) tx_state <= TX_DATA;
                end
                TX_DATA: if (tx_bit_end) begin
                    tx_bit <= tx_bit + 1'b1;
                    if (tx_bit == 3'd7) tx_state <= TX_STOP;
                end
                default: if (tx_bit_end) tx_state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tx_pop) tx_shift <= tx_dout;
        else if (tx_state == TX_DATA && tx_bit_end) tx_shift <= tx_shift >> 1;   // LSB first
    end

    always_comb begin
        case (tx_state)
            TX_START: tx = 1'b0;
            TX_DATA:  tx = tx_shift[0];
            default:  tx = 1'b1;
        endcase
    end

    // rx is asynchronous to clk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign rx_mid = (rx_cnt == BIT_MID);
    assign rx_end = (rx_cnt == BIT_END);
    assign rx_push = (rx_state == RX_STOP) && rx_end && !rx_full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_state <= RX_IDLE;
            rx_cnt <= '0;
            rx_bit <= '0;
            overrun <= 1'b0;
        end else begin
            if (rx_state == RX_IDLE || rx_end) rx_cnt <= '0;
            else rx_cnt <= rx_cnt + 1'b1;
            case (rx_state)
                RX_IDLE: if (!rx_sync) rx_state <= RX_START;
                RX_START: begin
                    rx_bit <= '0;
                    if (rx_mid && rx_sync) rx_state <= RX_IDLE;   // a glitch, not a start bit
                    else if (rx_end) rx_state <= RX_DATA;
                end
                RX_DATA: if (rx_end) begin
                    rx_bit <= rx_bit + 1'b1;
                    if (rx_bit == 3'd7) rx_state <= RX_STOP;
                end
                default: if (rx_end) rx_state <= RX_IDLE;
            endcase
            if (rx_state == RX_STOP && rx_end && rx_full) overrun <= 1'b1;   // byte is lost
            else if (status_rd) overrun <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_state == RX_DATA && rx_mid) rx_shift <= {rx_sync, rx_shift[7:1]};
    end

endmodule

/* hdl/soc_rom.sv */
`timescale 1ns/100ps

module soc_rom #(
    parameter int ROM_BITS = 4
) (
    input  logic                clk,
    input  logic                rom_sel,
    input  soc_bus_pkg::addr_t  mem_addr,
    output soc_bus_pkg::word_t  rom_rdata
);
    localparam int DEPTH = 1 << ROM_BITS;

    soc_bus_pkg::word_t rom_mem [0:DEPTH-1];

    initial begin
        $readmemh("rom_init.hex", rom_mem);
    end

    // word index, byte offset bits dropped
    always_ff @(posedge clk) begin
        if (rom_sel) begin
            rom_rdata <= rom_mem[mem_addr[ROM_BITS+1:2]];
        end
    end

endmodule

/* hdl/soc_ram.sv */
`timescale 1ns/100ps

module soc_ram #(
    parameter int RAM_BITS = 8
) (
    input  logic                clk,
    input  logic                ram_sel,
    input  soc_bus_pkg::addr_t  mem_addr,
    input  soc_bus_pkg::word_t  mem_wdata,
    input  soc_bus_pkg::strb_t  mem_wstrb,
    output soc_bus_pkg::word_t  ram_rdata
);
    localparam int DEPTH = 1 << RAM_BITS;

    logic [RAM_BITS-1:0] word_addr;

    assign word_addr = mem_addr[RAM_BITS+1:2];

    // one byte-wide array per lane so each strobe writes only its own byte
    for (genvar lane = 0; lane < 4; lane++) begin : g_lane
        soc_bus_pkg::byte_t lane_mem [0:DEPTH-1];

        always_ff @(posedge clk) begin
            if (ram_sel) begin
                if (mem_wstrb[lane]) begin
                    lane_mem[word_addr] <= mem_wdata[8*lane +: 8];
                end
                ram_rdata[8*lane +: 8] <= lane_mem[word_addr];   // old byte on a write
            end
        end
    end

endmodule

/* hdl/soc_bus_decode.sv */
`timescale 1ns/100ps

module soc_bus_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mem_valid,
    input  soc_bus_pkg::addr_t   mem_addr,
    input  soc_bus_pkg::word_t   mem_wdata,
    input  soc_bus_pkg::strb_t   mem_wstrb,
    input  soc_bus_pkg::word_t   rom_rdata,
    input  soc_bus_pkg::word_t   ram_rdata,
    input  soc_bus_pkg::byte_t   uart_rdata,
    input  logic                 uart_ack,
    input  logic                 tx_full,
    input  logic                 rx_empty,
    input  logic                 overrun,
    output logic                 mem_ready,
    output soc_bus_pkg::word_t   mem_rdata,
    output logic                 rom_sel,
    output logic                 ram_sel,
    output logic                 uart_req,
    output logic                 uart_wr,
    output soc_bus_pkg::byte_t   leds,
    output logic                 status_rd
);
    soc_bus_pkg::region_t region_q;
    logic                 busy;
    logic                 sel_q;
    logic                 accept;
    logic                 uart_region;
    logic                 ready_next;

    // a request is taken once, never while one is in flight or its ready is showing
    assign accept = mem_valid && !busy && !mem_ready;
    assign uart_region = (region_q == soc_bus_pkg::REGION_UART_DATA);
    assign ready_next = (sel_q && !uart_region) || uart_ack;   // UART data waits for its ack

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            sel_q <= 1'b0;
            region_q <= '0;
            mem_ready <= 1'b0;
        end else begin
            sel_q <= accept;
            mem_ready <= ready_next;
            if (accept) begin
                busy <= 1'b1;
                region_q <= mem_addr[soc_bus_pkg::REGION_MSB -: $bits(soc_bus_pkg::region_t)];
            end else if (ready_next) begin
                busy <= 1'b0;
            end
        end
    end

    assign rom_sel = sel_q && (region_q == soc_bus_pkg::REGION_ROM);
    assign ram_sel = sel_q && (region_q == soc_bus_pkg::REGION_RAM);
    assign uart_req = busy && uart_region;   // held until the ack comes back
    assign uart_wr = |mem_wstrb;

    // the status read is complete in its ready cycle, which lets the UART clear overrun
    assign status_rd = mem_ready && (region_q == soc_bus_pkg::REGION_UART_STATUS) && !(|mem_wstrb);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            leds <= '0;
        end else if (sel_q && (region_q == soc_bus_pkg::REGION_PORT) && mem_wstrb[0]) begin
            leds <= mem_wdata[7:0];
        end
    end

    always_comb begin
        case (region_q)
            soc_bus_pkg::REGION_ROM:         mem_rdata = rom_rdata;
            soc_bus_pkg::REGION_RAM:         mem_rdata = ram_rdata;
            soc_bus_pkg::REGION_PORT:        mem_rdata = {24'h0, leds};
            soc_bus_pkg::REGION_UART_DATA:   mem_rdata = {24'h0, uart_rdata};
            soc_bus_pkg::REGION_UART_STATUS: mem_rdata = {29'h0, overrun, rx_empty, tx_full};
            default:                         mem_rdata = '0;
        endcase
    end

endmodule

/* hdl/soc_periph_top.sv */
`timescale 1ns/100ps

module soc_periph_top #(
    parameter int ROM_BITS = 4,
    parameter int RAM_BITS = 8,
    parameter int FIFO_BITS = 2,
    parameter int CLK_DIV = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mem_valid,
    input  soc_bus_pkg::addr_t  mem_addr,
    input  soc_bus_pkg::word_t  mem_wdata,
    input  soc_bus_pkg::strb_t  mem_wstrb,
    input  logic                rx,
    output logic                mem_ready,
    output soc_bus_pkg::word_t  mem_rdata,
    output soc_bus_pkg::byte_t  leds,
    output logic                tx
);
    soc_bus_pkg::word_t rom_rdata;
    soc_bus_pkg::word_t ram_rdata;
    soc_bus_pkg::byte_t uart_rdata;
    logic               rom_sel, ram_sel;
    logic               uart_req, uart_wr, uart_ack;
    logic               tx_full, rx_empty, overrun, status_rd;

    soc_bus_decode u_decode (
        .clk(clk), .rst_n(rst_n),
        .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb),
        .rom_rdata(rom_rdata), .ram_rdata(ram_rdata), .uart_rdata(uart_rdata),
        .uart_ack(uart_ack), .tx_full(tx_full), .rx_empty(rx_empty), .overrun(overrun),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata),
        .rom_sel(rom_sel), .ram_sel(ram_sel), .uart_req(uart_req), .uart_wr(uart_wr),
        .leds(leds), .status_rd(status_rd)
    );

    soc_rom #(.ROM_BITS(ROM_BITS)) u_rom (
        .clk(clk), .rom_sel(rom_sel), .mem_addr(mem_addr), .rom_rdata(rom_rdata)
    );

    soc_ram #(.RAM_BITS(RAM_BITS)) u_ram (
        .clk(clk), .ram_sel(ram_sel), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb), .ram_rdata(ram_rdata)
    );

    // only byte lane 0 reaches the UART
    uart_fifo #(.FIFO_BITS(FIFO_BITS), .CLK_DIV(CLK_DIV)) u_uart (
        .clk(clk), .rst_n(rst_n),
        .uart_req(uart_req), .uart_wr(uart_wr), .wdata(mem_wdata[7:0]),
        .status_rd(status_rd), .rx(rx),
        .uart_ack(uart_ack), .rdata(uart_rdata),
        .tx_full(tx_full), .rx_empty(rx_empty), .overrun(overrun), .tx(tx)
    );

endmodule

/* tb/soc_periph_sva.sv */
`timescale 1ns/100ps

module soc_periph_sva (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mem_valid,
    input  soc_bus_pkg::addr_t  mem_addr,
    input  soc_bus_pkg::strb_t  mem_wstrb,
    input  logic                mem_ready,
    input  soc_bus_pkg::byte_t  leds,
    input  logic                tx
);
    logic port_write;

    assign port_write = mem_valid && mem_wstrb[0] &&
        (mem_addr[soc_bus_pkg::REGION_MSB -: 4] == soc_bus_pkg::REGION_PORT);

    ready_with_valid: assert property (@(posedge clk) disable iff (!rst_n) mem_ready |-> mem_valid)
        else $error("mem_ready is high while mem_valid is low");

    ready_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready |-> !$past(mem_ready))
        else $error("mem_ready stayed high for two cycles");

    tx_idle_in_reset: assert property (@(posedge clk) !rst_n |-> tx)
        else $error("tx left the idle level during reset");

    // the LED register takes byte 0 on the edge that ends the select cycle
    leds_on_port_write: assert property (@(posedge clk) disable iff (!rst_n)
        (leds != $past(leds)) |-> $past(port_write))
        else $error("leds changed without a port write to byte lane 0");

endmodule

/* tb/soc_periph_tb.sv */
`timescale 1ns/100ps

module soc_periph_tb;
    localparam int CLK_DIV = 8;
    localparam int FRAME_CYCLES = 10 * CLK_DIV;   // start bit, 8 data bits and stop bit
    localparam int TIMEOUT_CYCLES = 20000;   // the full run needs well under two thousand cycles
    localparam int DRIVE_DELAY = 1;
    localparam soc_bus_pkg::addr_t ROM_BASE = 32'h1000_0000;
    localparam soc_bus_pkg::addr_t RAM_BASE = 32'h2000_0000;
    localparam soc_bus_pkg::addr_t PORT_ADDR = 32'h3000_0000;
    localparam soc_bus_pkg::addr_t UART_DATA = 32'h4000_0000;
    localparam soc_bus_pkg::addr_t UART_STATUS = 32'h5000_0000;
    localparam soc_bus_pkg::word_t ST_TX_FULL = 32'h1;
    localparam soc_bus_pkg::word_t ST_RX_EMPTY = 32'h2;
    localparam soc_bus_pkg::word_t ST_OVERRUN = 32'h4;

    logic clk, rst_n, mem_valid, mem_ready;
    soc_bus_pkg::addr_t mem_addr;
    soc_bus_pkg::word_t mem_wdata, mem_rdata;
    soc_bus_pkg::strb_t mem_wstrb;
    soc_bus_pkg::byte_t leds, led_model;
    wire serial_line;   // tx looped back to rx
    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    int last_latency;
    logic [31:0] rand_state = 32'hf2fc_8710;
    soc_bus_pkg::word_t rom_expect [0:15];
    soc_bus_pkg::word_t ram_model [0:255];
    logic [7:0] ram_idx [0:7];

    soc_periph_top u_dut (
        .clk(clk), .rst_n(rst_n), .mem_valid(mem_valid), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .rx(serial_line),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata), .leds(leds), .tx(serial_line)
    );

    bind soc_periph_top soc_periph_sva u_sva (
        .clk(clk), .rst_n(rst_n), .mem_valid(mem_valid), .mem_addr(mem_addr),
        .mem_wstrb(mem_wstrb), .mem_ready(mem_ready), .leds(leds), .tx(tx)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d clock cycles, a bus access never completed", cycle_count);
        $display("Some tests failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_random();
        rand_state = xorshift32(rand_state);
        return rand_state;
    endfunction

    // lanes with a clear strobe keep their old byte
    function automatic soc_bus_pkg::word_t merge_lanes(input soc_bus_pkg::word_t old_word,
            input soc_bus_pkg::word_t new_word, input soc_bus_pkg::strb_t strb);
        soc_bus_pkg::word_t result;
        for (int lane = 0; lane < 4; lane++) begin
            result[8*lane +: 8] = strb[lane] ? new_word[8*lane +: 8] : old_word[8*lane +: 8];
        end
        return result;
    endfunction

    function automatic soc_bus_pkg::addr_t word_addr(input soc_bus_pkg::addr_t base,
            input logic [7:0] idx);
        return base | {22'h0, idx, 2'b00};
    endfunction

    task automatic check_value(input soc_bus_pkg::word_t got, input soc_bus_pkg::word_t expected,
            input string what);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAIL %0t ns: %s, got %08h expected %08h", $time, what, got, expected);
        end
    endtask

    // called 1 ns after a rising edge, returns at the same point of a later cycle
    task automatic transfer(input soc_bus_pkg::addr_t addr, input soc_bus_pkg::word_t wdata,
            input soc_bus_pkg::strb_t wstrb, output soc_bus_pkg::word_t rdata);
        mem_valid = 1'b1;
        mem_addr = addr;
        mem_wdata = wdata;
        mem_wstrb = wstrb;
        last_latency = 0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            last_latency++;
        end while (!mem_ready);
        rdata = mem_rdata;
        @(posedge clk);
        #DRIVE_DELAY;
        mem_valid = 1'b0;
        mem_wstrb = '0;
    endtask

    task automatic bus_write(input soc_bus_pkg::addr_t addr, input soc_bus_pkg::word_t wdata,
            input soc_bus_pkg::strb_t wstrb);
        soc_bus_pkg::word_t old_word;
        transfer(addr, wdata, wstrb, old_word);
    endtask

    task automatic bus_read(input soc_bus_pkg::addr_t addr, output soc_bus_pkg::word_t rdata);
        transfer(addr, '0, 4'h0, rdata);
    endtask

    task automatic rom_readback();
        soc_bus_pkg::word_t got;
        $readmemh("rom_init.hex", rom_expect);
        for (int i = 0; i < 16; i++) begin
            bus_read(ROM_BASE + 32'(i * 4), got);
            check_value(got, rom_expect[i], $sformatf("rom word %0d", i));
            check_value(32'(last_latency), 32'd2, $sformatf("rom word %0d latency", i));
        end
    endtask

    task automatic ram_byte_lanes();
        soc_bus_pkg::word_t data, got;
        soc_bus_pkg::strb_t strb;
        for (int i = 0; i < 8; i++) begin
            ram_idx[i] = 8'(next_random());
            data = next_random();
            bus_write(word_addr(RAM_BASE, ram_idx[i]), data, 4'hf);
            ram_model[ram_idx[i]] = data;
        end
        for (int i = 0; i < 8; i++) begin
            data = next_random();
            strb = 4'(next_random());
            if (strb == 4'h0) strb = 4'h9;   // all clear would turn it into a read
            transfer(word_addr(RAM_BASE, ram_idx[i]), data, strb, got);
            check_value(got, ram_model[ram_idx[i]], $sformatf("ram old word at %0d", ram_idx[i]));
            ram_model[ram_idx[i]] = merge_lanes(ram_model[ram_idx[i]], data, strb);
        end
        for (int i = 0; i < 8; i++) begin
            bus_read(word_addr(RAM_BASE, ram_idx[i]), got);
            check_value(got, ram_model[ram_idx[i]], $sformatf("ram word at %0d", ram_idx[i]));
        end
    endtask

    task automatic led_port_access();
        soc_bus_pkg::word_t data, got;
        data = next_random();
        bus_write(PORT_ADDR, data, 4'b0001);
        led_model = data[7:0];
        check_value({24'h0, leds}, {24'h0, led_model}, "leds after lane 0 write");
        check_value(32'(last_latency), 32'd2, "port write latency");
        data = next_random();
        data[7:0] = ~led_model;
        bus_write(PORT_ADDR, data, 4'b1110);
        check_value({24'h0, leds}, {24'h0, led_model}, "leds after write without lane 0");
        bus_read(PORT_ADDR, got);
        check_value(got, {24'h0, led_model}, "port readback");
    endtask

    task automatic uart_loopback();
        soc_bus_pkg::byte_t sent [0:2];
        soc_bus_pkg::word_t got;
        for (int i = 0; i < 3; i++) begin
            sent[i] = 8'(next_random());
            bus_write(UART_DATA, {24'h0, sent[i]}, 4'h1);
        end
        do begin
            bus_read(UART_STATUS, got);
        end while (got[1]);
        for (int i = 0; i < 3; i++) begin
            bus_read(UART_DATA, got);   // waits for bytes still on the line
            check_value(got, {24'h0, sent[i]}, $sformatf("loopback byte %0d", i));
        end
        bus_read(UART_STATUS, got);
        check_value(got, ST_RX_EMPTY, "status after loopback");
    endtask

    task automatic uart_back_pressure();
        soc_bus_pkg::byte_t sent [0:5];
        soc_bus_pkg::word_t got;
        for (int i = 0; i < 6; i++) sent[i] = 8'(next_random());
        for (int i = 0; i < 4; i++) bus_write(UART_DATA, {24'h0, sent[i]}, 4'h1);
        bus_read(UART_STATUS, got);   // the transmitter holds one byte, the FIFO three
        check_value(got, ST_RX_EMPTY, "status after four writes");
        bus_write(UART_DATA, {24'h0, sent[4]}, 4'h1);
        bus_read(UART_STATUS, got);
        check_value(got, ST_RX_EMPTY | ST_TX_FULL, "status with tx FIFO full");
        bus_write(UART_DATA, {24'h0, sent[5]}, 4'h1);
        repeat (8 * FRAME_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        for (int i = 0; i < 4; i++) begin
            bus_read(UART_DATA, got);
            check_value(got, {24'h0, sent[i]}, $sformatf("buffered byte %0d", i));
        end
        bus_read(UART_STATUS, got);
        check_value(got, ST_RX_EMPTY | ST_OVERRUN, "status with overrun");
        bus_read(UART_STATUS, got);
        check_value(got, ST_RX_EMPTY, "status after overrun read");
    endtask

    task automatic unmapped_access();
        soc_bus_pkg::word_t got;
        bus_write(word_addr(32'h0, ram_idx[0]), next_random(), 4'hf);
        check_value(32'(last_latency), 32'd2, "unmapped write latency");
        bus_read(word_addr(32'h0, ram_idx[0]), got);
        check_value(got, 32'h0, "unmapped read data");
        check_value(32'(last_latency), 32'd2, "unmapped read latency");
        bus_read(word_addr(RAM_BASE, ram_idx[0]), got);
        check_value(got, ram_model[ram_idx[0]], "ram word after unmapped write");
        check_value({24'h0, leds}, {24'h0, led_model}, "leds after unmapped write");
    endtask

    initial begin
        rst_n = 1'b0;
        mem_valid = 1'b0;
        mem_addr = '0;
        mem_wdata = '0;
        mem_wstrb = '0;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        rom_readback();
        ram_byte_lanes();
        led_port_access();
        uart_loopback();
        uart_back_pressure();
        unmapped_access();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* rom_init.hex */
// one 32-bit ROM word per line in hex, word index 0 first
00000093
00100113
002081b3
10000237
00022283
0052a023
fe5ff06f
a5a5a5a5
5a5a5a5a
0000ffff
ffff0000
12345678
87654321
00ff00ff
ff00ff00
c0ffee11

/* soc_periph.f */
hdl/soc_bus_pkg.sv
hdl/byte_fifo.sv
hdl/uart_fifo.sv
hdl/soc_rom.sv
hdl/soc_ram.sv
hdl/soc_bus_decode.sv
hdl/soc_periph_top.sv
tb/soc_periph_sva.sv
tb/soc_periph_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module soc_periph_tb -f soc_periph.f -o sim_soc_periph
./obj_dir/sim_soc_periph | tee sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi
